//--- project.f
+incdir+include
rtl/log_entry_pkg.sv
rtl/log_read_pkg.sv
rtl/event_stamper.sv
rtl/log_buffer.sv
rtl/read_port.sv
rtl/event_log.sv
verif/event_log_tb.sv

//--- run.sh
#!/bin/sh
# compile the event log with its testbench and run the simulation

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   -f project.f \
   --top-module event_log_tb \
   -Mdir obj_dir \
   && ./obj_dir/Vevent_log_tb > sim.log 2>&1

cat sim.log 2>/dev/null

# the log decides the result
grep -qs "TEST RESULT: PASS" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed, see sim.log"; exit 1; }

//--- verif/event_log_tb.sv
// event log testbench
`timescale 1ns/100ps
`include "log_params.svh"

module event_log_tb
   import log_entry_pkg::*;
   import log_read_pkg::*;
();

   logic                    clk;
   logic                    rstn;
   logic                    wvalid;
   logic [`LOG_DATA_W-1:0]  wdata;
   logic                    arvalid;
   arlen_t                  arlen;
   logic                    rready;
   logic                    rvalid;
   logic                    rlast;
   logic [`LOG_ENTRY_W-1:0] rdata;
   log_count_t              size;

   // every entry ever written, in capture order
   logic [`LOG_ENTRY_W-1:0] model [$];

   // owned by the stimulus process
   logic [31:0] lfsr_state;
   log_stamp_t  tb_cycle;
   log_stamp_t  tb_seq;
   int          dropped;
   int          burst_end;

   // owned by the comparison process
   int                      beats_accepted = 0;
   logic                    held_valid = 1'b0;
   logic [`LOG_ENTRY_W-1:0] held_rdata;
   log_count_t              held_size;
   logic                    held_rlast;

   event_log uut (
      .clk     (clk),
      .rstn    (rstn),
      .wvalid  (wvalid),
      .wdata   (wdata),
      .arvalid (arvalid),
      .arlen   (arlen),
      .rready  (rready),
      .rvalid  (rvalid),
      .rlast   (rlast),
      .rdata   (rdata),
      .size    (size)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   // right-shifting Galois LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      logic [31:0] next;
      next = state >> 1;
      if (state[0]) begin
         next = next ^ 32'h8020_0003;
      end
      return next;
   endfunction

   // one LFSR step per bit taken
   function automatic logic [31:0] rand_bits(input int width);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < width; i++) begin
         value = {value[30:0], lfsr_state[0]};
         lfsr_state = lfsr_step(lfsr_state);
      end
      return value;
   endfunction

   // expected stored word: data on top, then cycle stamp, then sequence stamp
   function automatic logic [`LOG_ENTRY_W-1:0] expected_entry(
      input logic [`LOG_DATA_W-1:0] data,
      input log_stamp_t             cycle,
      input log_stamp_t             seq
   );
      return {data, cycle, seq};
   endfunction

   // entries the log should hold right now
   function automatic int stored_count();
      return model.size() - dropped - beats_accepted;
   endfunction

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_failed(input string msg);
      abort_run($sformatf("FAILED at %0t: %s", $time, msg));
   endtask

   // one clock, inputs change 2 ns after the edge
   task automatic next_cycle();
      logic running;
      running = rstn;
      @(posedge clk);
      if (running) begin
         tb_cycle = tb_cycle + log_stamp_t'(1);
      end
      #2;
   endtask

   task automatic idle_cycles(input int count);
      for (int i = 0; i < count; i++) begin
         next_cycle();
      end
   endtask

   task automatic send_event(input logic [`LOG_DATA_W-1:0] data);
      wvalid = 1'b1;
      wdata  = data;
      // a full log loses its oldest entry
      if (stored_count() == `LOG_DEPTH) begin
         dropped++;
      end
      model.push_back(expected_entry(data, tb_cycle, tb_seq));
      tb_seq = tb_seq + log_stamp_t'(1);
      next_cycle();
      wvalid = 1'b0;
      assert (size == log_count_t'(stored_count())) else
         check_failed($sformatf("size %0d after event, expected %0d", size, stored_count()));
   endtask

   task automatic send_events(input int count, input logic with_gaps);
      int gap;
      for (int i = 0; i < count; i++) begin
         send_event(rand_bits(`LOG_DATA_W));
         if (with_gaps) begin
            gap = int'(rand_bits(2));
            idle_cycles(gap);
         end
      end
   endtask

   task automatic run_burst(input int beats, input logic random_ready);
      int waited;
      rready    = 1'b0;
      arvalid   = 1'b1;
      arlen     = arlen_t'(beats - 1);
      burst_end = beats_accepted + beats;
      next_cycle();
      arvalid = 1'b0;
      assert (rvalid) else check_failed("rvalid low after burst request");
      waited = 0;
      while (rvalid) begin
         if (random_ready) begin
            rready = rand_bits(1) != 32'd0;
         end else begin
            rready = 1'b1;
         end
         next_cycle();
         waited++;
         if (waited > 8 * beats + 40) begin
            abort_run("timeout: the burst did not end");
         end
      end
      rready = 1'b0;
      assert (beats_accepted == burst_end) else
         check_failed($sformatf("burst ended after %0d of %0d beats",
                                beats - (burst_end - beats_accepted), beats));
      assert (!rlast) else check_failed("rlast high after the burst");
   endtask

   // checks on every accepted beat and across every stalled cycle
   always @(negedge clk) begin
      if (held_valid) begin
         assert (rvalid && rdata == held_rdata && size == held_size && rlast == held_rlast)
            else check_failed("read outputs changed while rready was low");
      end
      if (rvalid && rready) begin
         assert (stored_count() > 0) else check_failed("beat accepted from an empty log");
         assert (rdata == model[dropped + beats_accepted]) else
            check_failed($sformatf("rdata %h, expected %h",
                                   rdata, model[dropped + beats_accepted]));
         assert (size == log_count_t'(stored_count())) else
            check_failed($sformatf("size %0d on beat, expected %0d", size, stored_count()));
         assert (rlast == (beats_accepted + 1 == burst_end)) else
            check_failed($sformatf("rlast %0b on beat %0d", rlast, beats_accepted));
         beats_accepted++;
      end
      held_valid = rvalid && !rready;
      held_rdata = rdata;
      held_size  = size;
      held_rlast = rlast;
   end

   initial begin
      int old_size;
      lfsr_state = 32'd90398;
      tb_cycle   = '0;
      tb_seq     = '0;
      dropped    = 0;
      burst_end  = 0;
      rstn       = 1'b0;
      wvalid     = 1'b0;
      wdata      = '0;
      arvalid    = 1'b0;
      arlen      = '0;
      rready     = 1'b0;

      idle_cycles(3);
      rstn = 1'b1;
      assert (!rvalid && !rlast && size == '0) else check_failed("bad state after reset");

      // stamps and capture order
      send_events(10, 1'b1);
      idle_cycles(2);
      run_burst(10, 1'b0);
      assert (size == '0) else check_failed($sformatf("size %0d after full read", size));

      // overwrite of the oldest entries
      send_events(40, 1'b0);
      assert (size == log_count_t'(`LOG_DEPTH)) else check_failed("size not at depth");
      idle_cycles(2);
      run_burst(16, 1'b0);

      // back-pressure with random rready
      send_events(12, 1'b1);
      idle_cycles(2);
      run_burst(12, 1'b1);

      // partial read, then the rest
      send_events(14, 1'b1);
      idle_cycles(2);
      old_size = stored_count();
      run_burst(5, 1'b1);
      assert (size == log_count_t'(old_size - 5)) else
         check_failed($sformatf("size %0d after partial read", size));
      idle_cycles(1);
      run_burst(old_size - 5, 1'b1);
      idle_cycles(2);

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

//--- rtl/event_log.sv
// event log top
`timescale 1ns/100ps
`include "log_params.svh"

module event_log
   import log_entry_pkg::*;
   import log_read_pkg::*;
(
   input  logic                    clk,
   input  logic                    rstn,

   // event capture
   input  logic                    wvalid,
   input  logic [`LOG_DATA_W-1:0]  wdata,

   // burst request
   input  logic                    arvalid,
   input  arlen_t                  arlen,

   // read data beats
   input  logic                    rready,
   output logic                    rvalid,
   output logic                    rlast,
   output logic [`LOG_ENTRY_W-1:0] rdata,

   // entries currently held
   output log_count_t              size
);

   // stamper to buffer
   logic       entry_valid;
   log_entry_u entry;

   // read port to buffer
   logic       pop;

   event_stamper u_stamper (
      .clk         (clk),
      .rstn        (rstn),
      .wvalid      (wvalid),
      .wdata       (wdata),
      .entry_valid (entry_valid),
      .entry       (entry)
   );

   // the registered head is the read data
   log_buffer u_buffer (
      .clk         (clk),
      .rstn        (rstn),
      .entry_valid (entry_valid),
      .entry       (entry),
      .pop         (pop),
      .head        (rdata),
      .size        (size)
   );

   read_port u_read_port (
      .clk         (clk),
      .rstn        (rstn),
      .arvalid     (arvalid),
      .arlen       (arlen),
      .rready      (rready),
      .rvalid      (rvalid),
      .rlast       (rlast),
      .pop         (pop)
   );

endmodule

//--- rtl/read_port.sv
// burst read port
`timescale 1ns/100ps

module read_port
   import log_read_pkg::*;
(
   input  logic   clk,
   input  logic   rstn,

   // burst request
   input  logic   arvalid,
   input  arlen_t arlen,

   // data beat handshake
   input  logic   rready,
   output logic   rvalid,
   output logic   rlast,

   // one entry consumed from the buffer
   output logic   pop
);

   beats_t remaining;
   beats_t burst_beats;
   logic   beat_done;

   // widen before the increment so 255 gives 256 beats
   assign burst_beats = beats_t'(arlen) + beats_t'(1);

   // valid for as long as beats are left
   assign rvalid = (remaining != '0);

   // final beat of the burst
   assign rlast = (remaining == beats_t'(1));

   assign beat_done = rvalid & rready;

   // each accepted beat takes the head entry
   assign pop = beat_done;

   // remaining-beat counter
   // a new request is only legal with no burst in flight
   always_ff @(posedge clk) begin
      if (!rstn) begin
         remaining <= '0;
      end else if (arvalid) begin
         remaining <= burst_beats;
      end else if (beat_done) begin
         remaining <= remaining - beats_t'(1);
      end
   end

endmodule

//--- rtl/log_buffer.sv
// circular log buffer
`timescale 1ns/100ps
`include "log_params.svh"

module log_buffer
   import log_entry_pkg::*;
(
   input  logic                    clk,
   input  logic                    rstn,

   // stamped entries from the input side
   input  logic                    entry_valid,
   input  log_entry_u              entry,

   // accepted read beat from the read port
   input  logic                    pop,

   // oldest entry and current fill level
   output logic [`LOG_ENTRY_W-1:0] head,
   output log_count_t              size
);

   logic [`LOG_ENTRY_W-1:0] mem [0:`LOG_DEPTH-1];

   log_ptr_t wr_ptr;
   log_ptr_t rd_ptr;
   log_ptr_t next_rd_ptr;

   logic [`LOG_DEPTH_LOG2-1:0] wr_addr;
   logic [`LOG_DEPTH_LOG2-1:0] head_addr;

   logic full;
   logic drop_oldest;
   logic rd_adv;

   // same slot with different wrap bits means every slot is in use
   assign full = (wr_ptr[`LOG_DEPTH_LOG2-1:0] == rd_ptr[`LOG_DEPTH_LOG2-1:0]) &&
                 (wr_ptr[`LOG_DEPTH_LOG2] != rd_ptr[`LOG_DEPTH_LOG2]);

   // a new entry into a full log pushes the oldest one out
   assign drop_oldest = full & entry_valid;

   // read side moves on a beat or on an overwrite, never twice
   assign rd_adv = pop | drop_oldest;

   assign next_rd_ptr = rd_ptr + log_ptr_t'(rd_adv);

   assign wr_addr   = wr_ptr[`LOG_DEPTH_LOG2-1:0];
   assign head_addr = next_rd_ptr[`LOG_DEPTH_LOG2-1:0];

   // pointer update
   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (entry_valid) begin
            wr_ptr <= wr_ptr + log_ptr_t'(1);
         end
         rd_ptr <= next_rd_ptr;
      end
   end

   // storage, the entry word is kept as a raw vector
   always_ff @(posedge clk) begin
      if (entry_valid) begin
         mem[wr_addr] <= entry.raw;
      end
   end

   // head looks one address ahead so it is ready right after a pop
   // an entry written at an edge shows up here one edge later
   always_ff @(posedge clk) begin
      head <= mem[head_addr];
   end

   // fill count follows pushes minus pops
   // push and pop together hold it, which keeps it at depth on overwrite
   always_ff @(posedge clk) begin
      if (!rstn) begin
         size <= '0;
      end else begin
         case ({entry_valid, rd_adv})
            2'b10: begin
               size <= size + log_count_t'(1);
            end
            2'b01: begin
               size <= size - log_count_t'(1);
            end
            default: begin
               size <= size;
            end
         endcase
      end
   end

endmodule

//--- rtl/event_stamper.sv
// event input stamper
`timescale 1ns/100ps
`include "log_params.svh"

module event_stamper
   import log_entry_pkg::*;
(
   input  logic                   clk,
   input  logic                   rstn,

   // raw event strobe and its payload
   input  logic                   wvalid,
   input  logic [`LOG_DATA_W-1:0] wdata,

   // stamped entry towards the buffer
   output logic                   entry_valid,
   output log_entry_u             entry
);

   log_stamp_t cycle_cnt;
   log_stamp_t seq_cnt;

   // free-running cycle count
   // starts at 0 in the first cycle out of reset and wraps
   always_ff @(posedge clk) begin
      if (!rstn) begin
         cycle_cnt <= '0;
      end else begin
         cycle_cnt <= cycle_cnt + log_stamp_t'(1);
      end
   end

   // number of events captured before the current one
   always_ff @(posedge clk) begin
      if (!rstn) begin
         seq_cnt <= '0;
      end else if (wvalid) begin
         seq_cnt <= seq_cnt + log_stamp_t'(1);
      end
   end

   // pack by fields, the stamps are the values before this edge
   always_comb begin
      entry.fields.data  = wdata;
      entry.fields.cycle = cycle_cnt;
      entry.fields.seq   = seq_cnt;
   end

   // no back-pressure on the write side
   assign entry_valid = wvalid;

endmodule

//--- rtl/log_read_pkg.sv
// burst read types
`include "log_params.svh"

package log_read_pkg;

   // burst length field as seen on the read request
   // number of beats is this value plus one
   typedef logic [`LOG_ARLEN_W-1:0] arlen_t;

   // remaining beats of the active burst
   // one bit wider so a full-length burst of 256 beats fits
   typedef logic [`LOG_ARLEN_W:0] beats_t;

endpackage

//--- rtl/log_entry_pkg.sv
// log entry types
`include "log_params.svh"

package log_entry_pkg;

   // one cycle or sequence stamp
   typedef logic [`LOG_STAMP_W-1:0] log_stamp_t;

   // field view of an entry, user data in the upper bits
   typedef struct packed {
      logic [`LOG_DATA_W-1:0] data;
      log_stamp_t             cycle;
      log_stamp_t             seq;
   } log_fields_t;

   // the stamper builds the word by fields
   // the buffer stores it and hands it out raw
   typedef union packed {
      logic [`LOG_ENTRY_W-1:0] raw;
      log_fields_t             fields;
   } log_entry_u;

   // buffer pointer, top bit is the wrap bit
   typedef logic [`LOG_DEPTH_LOG2:0] log_ptr_t;

   // fill count, 0 up to the full depth
   typedef logic [`LOG_DEPTH_LOG2:0] log_count_t;

endpackage

//--- include/log_params.svh
// event log parameters
`ifndef LOG_PARAMS_SVH
`define LOG_PARAMS_SVH

// user data carried with each event
`define LOG_DATA_W 32

// width of the cycle stamp and of the sequence stamp
`define LOG_STAMP_W 16

// log2 of the number of stored entries
`define LOG_DEPTH_LOG2 4

// burst length field, beats = length + 1
`define LOG_ARLEN_W 8

// derived sizes

// one stored entry holds data plus two stamps
`define LOG_ENTRY_W (`LOG_DATA_W + 2 * `LOG_STAMP_W)

`define LOG_DEPTH (1 << `LOG_DEPTH_LOG2)

`endif
